// ==== src.f ====
+incdir+design
design/aesPkg.sv
design/sramPkg.sv
design/sramSequencer.sv
design/byteKeyMixer.sv
design/addRoundKeyTop.sv
verification/addRoundKeyTb.sv

// ==== Makefile ====
TOOL = verilator
FLAGS = --binary --timing --assert -j 0
TOP = addRoundKeyTb
FILELIST = src.f
PASS_LINE = TEST RESULT: PASS

.PHONY: sim clean

# Build, run and look for the pass line in the output
sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_LINE)"

clean:
	rm -rf obj_dir

// ==== verification/addRoundKeyTb.sv ====
// Testbench for the AddRoundKey step
// Models the SRAM, runs fixed, back-to-back and random rounds and
// checks every output cycle against a timing and XOR reference
`timescale 1ns/1ns
`include "aesRound_defines.svh"

module addRoundKeyTb;

	localparam int ResetCycles = 10;
	localparam int NumRuns = 8;
	localparam int RunCycles = 45;
	localparam int TimeoutCycles = NumRuns * RunCycles + ResetCycles + 100;
	localparam int MemWords = 64;

	logic clk;
	logic n_rst;
	logic aroundEnable;
	aesPkg::block_t sramReadData;
	logic aroundFinished;
	logic sramRead;
	logic sramWrite;
	sramPkg::addr_t sramAddr;
	aesPkg::block_t sramWriteData;

	aesPkg::block_t mem [MemWords];
	logic [31:0] rngState = 32'd28;
	int runCycle = 0;
	int cycleCount = 0;
	int checkCount = 0;
	int errorCount = 0;

	addRoundKeyTop addRoundKeyTop_i
	(
		.clk(clk),
		.n_rst(n_rst),
		.aroundEnable(aroundEnable),
		.sramReadData(sramReadData),
		.aroundFinished(aroundFinished),
		.sramRead(sramRead),
		.sramWrite(sramWrite),
		.sramAddr(sramAddr),
		.sramWriteData(sramWriteData)
	);

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x;
		y = y ^ (y << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic aesPkg::block_t randomBlock();
		aesPkg::block_t value;
		value = '0;
		for (int w = 0; w < 4; w++)
		begin
			rngState = xorshift32(rngState);
			value[w*32 +: 32] = rngState;
		end
		return value;
	endfunction

	// AddRoundKey is a plain bytewise XOR of key and state
	function automatic aesPkg::block_t addRoundKeyRef(input aesPkg::block_t key,
		input aesPkg::block_t state);
		aesPkg::block_t mixed;
		mixed = '0;
		for (int k = 0; k < `AES_NUM_BYTES; k++)
		begin
			mixed[k*`AES_BYTE_BITS +: `AES_BYTE_BITS] =
				key[k*`AES_BYTE_BITS +: `AES_BYTE_BITS] ^
				state[k*`AES_BYTE_BITS +: `AES_BYTE_BITS];
		end
		return mixed;
	endfunction

	task automatic checkValue(input string name, input aesPkg::block_t actual,
		input aesPkg::block_t expected);
		checkCount = checkCount + 1;
		if (actual !== expected)
		begin
			errorCount = errorCount + 1;
			$display("ERR t=%0t signal=%s expected=%h actual=%h", $time, name, expected, actual);
		end
	endtask

	task automatic pulseEnable();
		@(posedge clk);
		aroundEnable <= 1'b1;
		@(posedge clk);
		aroundEnable <= 1'b0;
	endtask

	task automatic waitFinished();
		do
		begin
			@(negedge clk);
		end
		while (aroundFinished !== 1'b1);
	endtask

	// SRAM answers a read one cycle after the strobe
	always @(posedge clk)
	begin
		if (sramRead)
		begin
			sramReadData <= mem[sramAddr[5:0]];
		end
		if (sramWrite)
		begin
			mem[sramAddr[5:0]] <= sramWriteData;
		end
	end

	// Cycle position within a run, 0 when idle
	always @(posedge clk)
	begin
		if (!n_rst)
		begin
			runCycle <= 0;
		end
		else if (runCycle == 0)
		begin
			runCycle <= aroundEnable ? 1 : 0;
		end
		else if (runCycle == 41)
		begin
			runCycle <= 0;
		end
		else
		begin
			runCycle <= runCycle + 1;
		end
	end

	// Compare every port against the expected cycle pattern
	always @(negedge clk)
	begin
		logic expRead;
		logic expWrite;
		logic expFinished;
		sramPkg::addr_t expAddr;
		aesPkg::block_t expData;
		expRead = 1'b0;
		expWrite = 1'b0;
		expFinished = 1'b0;
		expAddr = '0;
		expData = '0;
		case (runCycle)
			1: expAddr = sramPkg::addr_t'(`KEY_ADDR);
			2:
			begin
				expAddr = sramPkg::addr_t'(`KEY_ADDR);
				expRead = 1'b1;
			end
			4: expAddr = sramPkg::addr_t'(`STATE_ADDR);
			5:
			begin
				expAddr = sramPkg::addr_t'(`STATE_ADDR);
				expRead = 1'b1;
			end
			39, 40:
			begin
				expAddr = sramPkg::addr_t'(`STATE_ADDR);
				expData = addRoundKeyRef(mem[`KEY_ADDR], mem[`STATE_ADDR]);
				expWrite = (runCycle == 40);
			end
			41: expFinished = 1'b1;
			default:
			begin
			end
		endcase
		checkValue("sramRead", aesPkg::block_t'(sramRead), aesPkg::block_t'(expRead));
		checkValue("sramWrite", aesPkg::block_t'(sramWrite), aesPkg::block_t'(expWrite));
		checkValue("sramAddr", aesPkg::block_t'(sramAddr), aesPkg::block_t'(expAddr));
		checkValue("aroundFinished", aesPkg::block_t'(aroundFinished),
			aesPkg::block_t'(expFinished));
		if (runCycle == 40)
		begin
			for (int k = 0; k < `AES_NUM_BYTES; k++)
			begin
				checkValue($sformatf("sramWriteData byte %0d", k),
					aesPkg::block_t'(sramWriteData[k*`AES_BYTE_BITS +: `AES_BYTE_BITS]),
					aesPkg::block_t'(expData[k*`AES_BYTE_BITS +: `AES_BYTE_BITS]));
			end
		end
		else
		begin
			checkValue("sramWriteData", sramWriteData, expData);
		end
	end

	initial
	begin
		while (cycleCount < TimeoutCycles)
		begin
			@(posedge clk);
			cycleCount = cycleCount + 1;
		end
		$display("Run timed out after %0d cycles without reaching the end", TimeoutCycles);
		$display("TEST RESULT: FAIL");
		$finish;
	end

	initial
	begin
		aesPkg::block_t fixedKey;
		aesPkg::block_t fixedState;
		aesPkg::block_t keys [6];
		aesPkg::block_t states [7];
		aesPkg::block_t lastKey;
		aesPkg::block_t lastState;
		n_rst = 1'b0;
		aroundEnable = 1'b0;
		sramReadData = '0;
		for (int a = 0; a < MemWords; a++)
		begin
			mem[a] = {8{16'(a) ^ 16'h5A3C}};
		end
		fixedKey = 128'h0f0e0d0c_0b0a0908_07060504_03020100;
		fixedState = 128'hff112233_44556677_8899aabb_ccddee80;
		repeat (ResetCycles) @(posedge clk);
		n_rst <= 1'b1;
		repeat (5) @(posedge clk);

		// Single run with known key and state
		@(negedge clk);
		mem[`KEY_ADDR] = fixedKey;
		mem[`STATE_ADDR] = fixedState;
		pulseEnable();
		waitFinished();
		checkValue("state word after run 1", mem[`STATE_ADDR],
			addRoundKeyRef(fixedKey, fixedState));

		// Enable held high, keys repeat in pairs to undo the XOR
		keys[0] = randomBlock();
		keys[1] = keys[0];
		keys[2] = randomBlock();
		keys[3] = randomBlock();
		keys[4] = randomBlock();
		keys[5] = keys[4];
		states[0] = mem[`STATE_ADDR];
		mem[`KEY_ADDR] = keys[0];
		@(posedge clk);
		aroundEnable <= 1'b1;
		for (int i = 0; i < 6; i++)
		begin
			waitFinished();
			states[i+1] = mem[`STATE_ADDR];
			checkValue($sformatf("state word after run %0d", i + 2), states[i+1],
				addRoundKeyRef(keys[i], states[i]));
			if (i < 5)
			begin
				mem[`KEY_ADDR] = keys[i+1];
			end
		end
		@(posedge clk);
		aroundEnable <= 1'b0;
		checkValue("state restored by key pair 1", states[2], states[0]);
		checkValue("state restored by key pair 2", states[6], states[4]);

		// Fresh random key and state
		repeat (3) @(negedge clk);
		lastKey = randomBlock();
		lastState = randomBlock();
		mem[`KEY_ADDR] = lastKey;
		mem[`STATE_ADDR] = lastState;
		pulseEnable();
		waitFinished();
		checkValue("state word after run 8", mem[`STATE_ADDR],
			addRoundKeyRef(lastKey, lastState));
		repeat (5) @(negedge clk);

		$display("Checks: %0d, errors: %0d", checkCount, errorCount);
		if (errorCount == 0)
		begin
			$display("TEST RESULT: PASS");
		end
		else
		begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

// ==== design/addRoundKeyTop.sv ====
// AddRoundKey step top level
// Sequencer drives the SRAM port, the mixer does the byte XORs
`timescale 1ns/1ns

module addRoundKeyTop
(
	input logic clk,
	input logic n_rst,
	input logic aroundEnable,
	input aesPkg::block_t sramReadData,
	output logic aroundFinished,
	output logic sramRead,
	output logic sramWrite,
	output sramPkg::addr_t sramAddr,
	output aesPkg::block_t sramWriteData
);

	logic loadKey;
	logic loadState;
	logic mixStart;
	logic mixDone;
	aesPkg::block_t result;

	sramSequencer sequencer
	(
		.clk(clk),
		.n_rst(n_rst),
		.aroundEnable(aroundEnable),
		.mixDone(mixDone),
		.result(result),
		.sramRead(sramRead),
		.sramWrite(sramWrite),
		.sramAddr(sramAddr),
		.sramWriteData(sramWriteData),
		.loadKey(loadKey),
		.loadState(loadState),
		.mixStart(mixStart),
		.aroundFinished(aroundFinished)
	);

	byteKeyMixer mixer
	(
		.clk(clk),
		.n_rst(n_rst),
		.sramReadData(sramReadData),
		.loadKey(loadKey),
		.loadState(loadState),
		.mixStart(mixStart),
		.result(result),
		.mixDone(mixDone)
	);

endmodule

// ==== design/byteKeyMixer.sv ====
// Byte-serial AddRoundKey mixer
// Holds the round key and the state, then XORs them one byte per
// set/capture pair, byte 0 first, into the result block
`timescale 1ns/1ns
`include "aesRound_defines.svh"

module byteKeyMixer
(
	input logic clk,
	input logic n_rst,
	input aesPkg::block_t sramReadData,
	input logic loadKey,
	input logic loadState,
	input logic mixStart,
	output aesPkg::block_t result,
	output logic mixDone
);

	logic active;
	logic capturePhase;
	logic lastByte;
	aesPkg::byteIndex_t byteIdx;

	aesPkg::block_t keyReg;
	aesPkg::block_t stateReg;
	aesPkg::byte_t keyByte;
	aesPkg::byte_t stateByte;

	assign lastByte = (byteIdx == aesPkg::byteIndex_t'(`AES_NUM_BYTES - 1));

	// High in the capture cycle of byte 15 only
	assign mixDone = active && capturePhase && lastByte;

	always_ff @(posedge clk or negedge n_rst)
	begin
		if (!n_rst)
		begin
			active <= 1'b0;
			capturePhase <= 1'b0;
			byteIdx <= '0;
		end
		else if (mixStart)
		begin
			active <= 1'b1;
			capturePhase <= 1'b0;
			byteIdx <= '0;
		end
		else if (active)
		begin
			capturePhase <= !capturePhase;
			if (capturePhase)
			begin
				if (lastByte)
				begin
					active <= 1'b0;
				end
				else
				begin
					byteIdx <= byteIdx + 1'b1;
				end
			end
		end
	end

	// Block registers straight from the SRAM read bus
	always_ff @(posedge clk)
	begin
		if (loadKey)
		begin
			keyReg <= sramReadData;
		end
		if (loadState)
		begin
			stateReg <= sramReadData;
		end
	end

	// Set cycle picks the lane, capture cycle stores the XOR
	always_ff @(posedge clk)
	begin
		if (active && !capturePhase)
		begin
			keyByte <= keyReg[byteIdx*`AES_BYTE_BITS +: `AES_BYTE_BITS];
			stateByte <= stateReg[byteIdx*`AES_BYTE_BITS +: `AES_BYTE_BITS];
		end
		if (active && capturePhase)
		begin
			result[byteIdx*`AES_BYTE_BITS +: `AES_BYTE_BITS] <= keyByte ^ stateByte;
		end
	end

	// Sequencer must not reload key or state under a running mix
	noLoadWhileMixing: assert property (
		@(posedge clk) disable iff (!n_rst) active |-> !(loadKey || loadState));

endmodule

// ==== design/sramSequencer.sv ====
// SRAM sequencer for the AddRoundKey step
// Reads the key and the state, hands them to the byte mixer,
// writes the result back and flags the end of the step
`timescale 1ns/1ns
`include "aesRound_defines.svh"

module sramSequencer
(
	input logic clk,
	input logic n_rst,
	input logic aroundEnable,
	input logic mixDone,
	input aesPkg::block_t result,
	output logic sramRead,
	output logic sramWrite,
	output sramPkg::addr_t sramAddr,
	output aesPkg::block_t sramWriteData,
	output logic loadKey,
	output logic loadState,
	output logic mixStart,
	output logic aroundFinished
);

	sramPkg::phase_t phase;
	sramPkg::phase_t nextPhase;

	always_ff @(posedge clk or negedge n_rst)
	begin
		if (!n_rst)
		begin
			phase <= sramPkg::idle;
		end
		else
		begin
			phase <= nextPhase;
		end
	end

	always_comb
	begin
		nextPhase = phase;
		case (phase)
			sramPkg::idle:
			begin
				if (aroundEnable)
				begin
					nextPhase = sramPkg::keyAddr;
				end
			end
			sramPkg::keyAddr: nextPhase = sramPkg::keyRead;
			sramPkg::keyRead: nextPhase = sramPkg::keyCapture;
			sramPkg::keyCapture: nextPhase = sramPkg::stateAddr;
			sramPkg::stateAddr: nextPhase = sramPkg::stateRead;
			sramPkg::stateRead: nextPhase = sramPkg::stateCapture;
			sramPkg::stateCapture: nextPhase = sramPkg::mixing;
			sramPkg::mixing:
			begin
				// Mixer flags the capture of the last byte
				if (mixDone)
				begin
					nextPhase = sramPkg::writeSetup;
				end
			end
			sramPkg::writeSetup: nextPhase = sramPkg::writeStrobe;
			sramPkg::writeStrobe: nextPhase = sramPkg::finish;
			sramPkg::finish: nextPhase = sramPkg::idle;
			default: nextPhase = sramPkg::idle;
		endcase
	end

	always_comb
	begin
		sramRead = 1'b0;
		sramWrite = 1'b0;
		sramAddr = '0;
		sramWriteData = '0;
		loadKey = 1'b0;
		loadState = 1'b0;
		mixStart = 1'b0;
		aroundFinished = 1'b0;
		case (phase)
			sramPkg::keyAddr:
			begin
				sramAddr = sramPkg::addr_t'(`KEY_ADDR);
			end
			sramPkg::keyRead:
			begin
				sramAddr = sramPkg::addr_t'(`KEY_ADDR);
				sramRead = 1'b1;
			end
			// Read data is valid one cycle after the strobe
			sramPkg::keyCapture:
			begin
				loadKey = 1'b1;
			end
			sramPkg::stateAddr:
			begin
				sramAddr = sramPkg::addr_t'(`STATE_ADDR);
			end
			sramPkg::stateRead:
			begin
				sramAddr = sramPkg::addr_t'(`STATE_ADDR);
				sramRead = 1'b1;
			end
			// Byte steps begin right after the state lands
			sramPkg::stateCapture:
			begin
				loadState = 1'b1;
				mixStart = 1'b1;
			end
			sramPkg::writeSetup:
			begin
				sramAddr = sramPkg::addr_t'(`STATE_ADDR);
				sramWriteData = result;
			end
			sramPkg::writeStrobe:
			begin
				sramAddr = sramPkg::addr_t'(`STATE_ADDR);
				sramWriteData = result;
				sramWrite = 1'b1;
			end
			sramPkg::finish:
			begin
				aroundFinished = 1'b1;
			end
			default:
			begin
			end
		endcase
	end

	// Mixer finishes only while the FSM waits on it
	doneInMixing: assert property (
		@(posedge clk) disable iff (!n_rst) mixDone |-> (phase == sramPkg::mixing));

	// Sixteen set/capture pairs between start and done
	doneAfterByteSteps: assert property (
		@(posedge clk) disable iff (!n_rst)
		mixDone |-> $past(mixStart, 2 * `AES_NUM_BYTES));

endmodule

// ==== design/sramPkg.sv ====
// SRAM-side types
// Address type and the phases of the SRAM sequencer
`include "aesRound_defines.svh"

package sramPkg;

	typedef logic [`SRAM_ADDR_BITS-1:0] addr_t;

	// Each read takes address, strobe and capture cycles
	typedef enum logic [3:0] {
		idle,
		keyAddr,
		keyRead,
		keyCapture,
		stateAddr,
		stateRead,
		stateCapture,
		mixing,
		writeSetup,
		writeStrobe,
		finish
	} phase_t;

endpackage

// ==== design/aesPkg.sv ====
// AES cipher-side types
// Block, byte lane and byte index used by the AddRoundKey step
`include "aesRound_defines.svh"

package aesPkg;

	// Full 128-bit key, state or result
	typedef logic [`AES_BLOCK_BITS-1:0] block_t;

	// One byte lane of a block
	typedef logic [`AES_BYTE_BITS-1:0] byte_t;

	// Walks byte 0 up to byte 15
	typedef logic [$clog2(`AES_NUM_BYTES)-1:0] byteIndex_t;

endpackage

// ==== design/aesRound_defines.svh ====
// AES AddRoundKey step shared constants
// Block and byte geometry plus the fixed SRAM word locations
`ifndef AES_ROUND_DEFINES_SVH
`define AES_ROUND_DEFINES_SVH

// Cipher block geometry
`define AES_BLOCK_BITS 128
`define AES_BYTE_BITS 8
`define AES_NUM_BYTES 16

// SRAM port width
`define SRAM_ADDR_BITS 16

// Word addresses of the round key and the state
`define KEY_ADDR 16
`define STATE_ADDR 32

`endif
